/* common/routerPkg.sv */
package routerPkg;

  // Port count and widths.
  localparam int NumPorts    = 5;
  localparam int FlitIdWidth = 3;
  localparam int LengthWidth = 12;
  localparam int DataWidth   = 16;

  // Input ports of the router, also the bit index of every port vector.
  typedef enum logic [2:0]
  {
    L = 3'd0,
    N = 3'd1,
    E = 3'd2,
    W = 3'd3,
    S = 3'd4
  } portIdx;

  // Flit ids.
  typedef enum logic [FlitIdWidth-1:0]
  {
    IDLE_FLIT = 3'd0,
    HEAD      = 3'd1,
    BODY      = 3'd2,
    TAIL      = 3'd4
  } flitKind;

  // One-hot arbiter states. Bit p+1 is the grant of port p.
  typedef enum logic [5:0]
  {
    IDLE    = 6'b000001,
    GRANT_L = 6'b000010,
    GRANT_N = 6'b000100,
    GRANT_E = 6'b001000,
    GRANT_W = 6'b010000,
    GRANT_S = 6'b100000
  } arbState;

endpackage

/* arbiter/grantFsm.sv */
`timescale 1ns/100ps

module grantFsm
  import routerPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] req,
  input  logic [NumPorts-1:0] timesUp,
  output logic [NumPorts-1:0] run,
  output logic [NumPorts-1:0] grant
);

  arbState state;
  arbState stateNext;
  portIdx  heldPort;
  logic    heldValid;

  // First requester among span ports, starting at first and wrapping around.
  function automatic arbState pickNext(
    input int                  first,
    input int                  span,
    input logic [NumPorts-1:0] reqs
  );
    arbState pick;
    logic    found;
    int      port;
    pick  = IDLE;
    found = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      port = (first + i) % NumPorts;
      if (i < span && !found && reqs[port])
      begin
        pick  = arbState'(6'b000001 << (port + 1));
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= IDLE;
    else
      state <= stateNext;
  end

  // Which port the current state holds.
  always_comb
  begin
    heldPort  = L;
    heldValid = 1'b1;
    case (state)
      GRANT_L: heldPort = L;
      GRANT_N: heldPort = N;
      GRANT_E: heldPort = E;
      GRANT_W: heldPort = W;
      GRANT_S: heldPort = S;
      default: heldValid = 1'b0;  // IDLE or an illegal code.
    endcase
  end

  always_comb
  begin
    run       = '0;
    stateNext = IDLE;
    if (state == IDLE)
    begin
      // Fixed order L, N, E, W, S.
      stateNext = pickNext(0, NumPorts, req);
    end
    else if (heldValid)
    begin
      if (req[heldPort] && !timesUp[heldPort])
      begin
        run[heldPort] = 1'b1;
        stateNext     = state;  // Keep the link.
      end
      else
      begin
        // Rotate past the released port, never back to it directly.
        stateNext = pickNext((int'(heldPort) + 1) % NumPorts, NumPorts - 1, req);
      end
    end
  end

  assign grant = state[NumPorts:1];

endmodule

/* arbiter/holdTimers.sv */
`timescale 1ns/100ps

module holdTimers
  import routerPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [NumPorts-1:0][FlitIdWidth-1:0]   flitId,
  input  logic [NumPorts-1:0][LengthWidth-1:0]   length,
  input  logic [NumPorts-1:0]                    run,
  output logic [NumPorts-1:0]                    timesUp
);

  logic [NumPorts-1:0][LengthWidth-1:0] limit;
  logic [NumPorts-1:0][LengthWidth-1:0] count;

  // Length latch per port, loaded by any head flit.
  always_ff @(posedge clk)
  begin
    if (rst)
      limit <= '0;
    else
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (flitKind'(flitId[p]) == HEAD)
          limit[p] <= length[p];
      end
    end
  end

  // Hold counters run only while the port keeps the link.
  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (run[p])
          count[p] <= count[p] + LengthWidth'(1);
        else
          count[p] <= '0;
      end
    end
  end

  always_comb
  begin
    for (int p = 0; p < NumPorts; p++)
      timesUp[p] = (count[p] == limit[p]);  // Time up at the latched length.
  end

endmodule

/* verilog/linkMux.sv */
`timescale 1ns/100ps

module linkMux
  import routerPkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [NumPorts-1:0]                  grant,
  input  logic [NumPorts-1:0]                  req,
  input  logic [NumPorts-1:0][DataWidth-1:0]   data,
  output logic                                 outValid,
  output logic [DataWidth-1:0]                 outData,
  output portIdx                               outPort
);

  portIdx               selPort;
  logic [DataWidth-1:0] selData;
  logic                 selActive;
  logic                 hasGrant;

  // Index of the one-hot grant and the word behind it.
  always_comb
  begin
    selPort   = L;
    selData   = data[0];
    selActive = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
      begin
        selPort   = portIdx'(3'(p));
        selData   = data[p];
        selActive = req[p];  // Granted port still asking.
      end
    end
  end

  assign hasGrant = |grant;

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= selActive;
  end

  // Payload holds while the link is idle.
  always_ff @(posedge clk)
  begin
    if (hasGrant)
    begin
      outData <= selData;
      outPort <= selPort;
    end
  end

endmodule

/* verilog/outputArbiter.sv */
`timescale 1ns/100ps

module outputArbiter
  import routerPkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [NumPorts-1:0]                    req,
  input  logic [NumPorts-1:0][FlitIdWidth-1:0]   flitId,
  input  logic [NumPorts-1:0][LengthWidth-1:0]   length,
  input  logic [NumPorts-1:0][DataWidth-1:0]     data,
  output logic [NumPorts-1:0]                    grant,
  output logic                                   outValid,
  output logic [DataWidth-1:0]                   outData,
  output portIdx                                 outPort
);

  logic [NumPorts-1:0] run;
  logic [NumPorts-1:0] timesUp;

  // Rotating-priority grant state.
  grantFsm u_grantFsm
  (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .timesUp (timesUp),
    .run     (run),
    .grant   (grant)
  );

  // Per-port hold limits.
  holdTimers u_holdTimers
  (
    .clk     (clk),
    .rst     (rst),
    .flitId  (flitId),
    .length  (length),
    .run     (run),
    .timesUp (timesUp)
  );

  linkMux u_linkMux
  (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .data     (data),
    .outValid (outValid),
    .outData  (outData),
    .outPort  (outPort)
  );

endmodule

/* verif/tbOutputArbiter.sv */
`timescale 1ns/100ps

module tbOutputArbiter
  import routerPkg::*;
();

  localparam int ClkPeriod      = 8;
  localparam int ResetCycles    = 5;
  localparam int DirectedCycles = 100;
  localparam int RandomCycles   = 400;
  localparam int MarginCycles   = 50;

  logic                                 clk = 1'b0;
  logic                                 rst;
  logic [NumPorts-1:0]                  req;
  logic [NumPorts-1:0][FlitIdWidth-1:0] flitId;
  logic [NumPorts-1:0][LengthWidth-1:0] length;
  logic [NumPorts-1:0][DataWidth-1:0]   data;
  logic [NumPorts-1:0]                  grant;
  logic                                 outValid;
  logic [DataWidth-1:0]                 outData;
  portIdx                               outPort;

  // Reference model state.
  int                     mHeld;  // Held port or -1 while idle.
  logic [LengthWidth-1:0] mLimit [NumPorts];
  logic [LengthWidth-1:0] mCount [NumPorts];
  logic                   mValid;
  logic                   mLoaded;
  logic [DataWidth-1:0]   mData;
  portIdx                 mPort;
  logic [NumPorts-1:0]    expGrant;
  logic [15:0]            lfsr = 16'd7;

  outputArbiter u_outputArbiter
  (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .flitId   (flitId),
    .length   (length),
    .data     (data),
    .grant    (grant),
    .outValid (outValid),
    .outData  (outData),
    .outPort  (outPort)
  );

  always #(ClkPeriod / 2) clk = ~clk;

  // Fibonacci LFSR with taps 16, 14, 13 and 11. One step per bit.
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // Next owner after a release; released < 0 means the link was idle.
  function automatic int nextHolder(input int released, input logic [NumPorts-1:0] reqs);
    int cand;
    int tries;
    cand  = (released < 0) ? 0 : (released + 1) % NumPorts;
    tries = (released < 0) ? NumPorts : NumPorts - 1;
    while (tries > 0 && !reqs[cand])
    begin
      cand  = (cand + 1) % NumPorts;
      tries = tries - 1;
    end
    return (tries > 0) ? cand : -1;
  endfunction

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Run stopped.");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] gotVal);
    $display("ERR time=%0t signal=%s expected=%0h actual=%0h", $time, name, expVal, gotVal);
    stopWithFailure("Output mismatch against the reference model.");
  endtask

  // One stimulus cycle. Head flits carry len and data words are random.
  task automatic drive(input logic [NumPorts-1:0] reqs, input logic [NumPorts-1:0] heads,
                       input int len);
    @(posedge clk);
    req <= reqs;
    for (int p = 0; p < NumPorts; p++)
    begin
      flitId[p] <= heads[p] ? HEAD : BODY;
      length[p] <= LengthWidth'(len);
      data[p]   <= DataWidth'(takeBits(DataWidth));
    end
  endtask

  always @(posedge clk)
  begin
    logic keep;
    keep = (mHeld >= 0) && req[mHeld] && (mCount[mHeld] != mLimit[mHeld]);
    if (rst)
    begin
      mHeld   <= -1;
      mValid  <= 1'b0;
      mLoaded <= 1'b0;
      for (int p = 0; p < NumPorts; p++)
      begin
        mLimit[p] <= '0;
        mCount[p] <= '0;
      end
    end
    else
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        if (flitId[p] == HEAD)
          mLimit[p] <= length[p];  // Any head flit, granted or not.
        mCount[p] <= (keep && p == mHeld) ? mCount[p] + LengthWidth'(1) : '0;
      end
      mHeld  <= keep ? mHeld : nextHolder(mHeld, req);
      mValid <= (mHeld >= 0) && req[mHeld];
      if (mHeld >= 0)
      begin
        mData   <= data[mHeld];
        mPort   <= portIdx'(mHeld);
        mLoaded <= 1'b1;
      end
    end
  end

  always_comb
    expGrant = (mHeld < 0) ? '0 : NumPorts'(1) << mHeld;

  checkGrant: assert property (@(posedge clk) disable iff (rst) grant == expGrant)
    else reportMismatch("grant", 32'($sampled(expGrant)), 32'($sampled(grant)));
  checkValid: assert property (@(posedge clk) disable iff (rst) outValid == mValid)
    else reportMismatch("outValid", 32'($sampled(mValid)), 32'($sampled(outValid)));
  checkData: assert property (@(posedge clk) disable iff (rst) !mLoaded || outData == mData)
    else reportMismatch("outData", 32'($sampled(mData)), 32'($sampled(outData)));
  checkPort: assert property (@(posedge clk) disable iff (rst) !mLoaded || outPort == mPort)
    else reportMismatch("outPort", 32'($sampled(mPort)), 32'($sampled(outPort)));

  initial
  begin
    #((ResetCycles + DirectedCycles + RandomCycles + MarginCycles) * ClkPeriod);
    stopWithFailure("Timeout: the stimulus did not finish in the expected time.");
  end

  initial
  begin
    logic [NumPorts-1:0] reqs;
    logic [NumPorts-1:0] heads;
    rst    = 1'b1;
    req    = '0;
    flitId = '0;
    length = '0;
    data   = '0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // All ports at once, then E and S from idle.
    drive(5'b11111, 5'b11111, 2);
    repeat (24) drive(5'b11111, 5'b00000, 0);
    repeat (3) drive(5'b00000, 5'b00000, 0);
    repeat (4) drive(5'b10100, 5'b00000, 0);
    repeat (3) drive(5'b00000, 5'b00000, 0);

    // N held past its length; W gets a head meanwhile.
    drive(5'b00010, 5'b00010, 6);
    repeat (4) drive(5'b00010, 5'b00000, 0);
    drive(5'b00010, 5'b01000, 1);
    repeat (7) drive(5'b00010, 5'b00000, 0);
    repeat (2) drive(5'b00000, 5'b00000, 0);
    repeat (4) drive(5'b01000, 5'b00000, 0);
    repeat (2) drive(5'b00000, 5'b00000, 0);

    // Early drops with long limits.
    drive(5'b11111, 5'b11111, 7);
    repeat (2) drive(5'b00000, 5'b00000, 0);
    repeat (3) drive(5'b01000, 5'b00000, 0);
    repeat (3) drive(5'b00000, 5'b00000, 0);
    repeat (2) drive(5'b10001, 5'b00000, 0);
    repeat (3) drive(5'b10000, 5'b00000, 0);
    repeat (3) drive(5'b00000, 5'b00000, 0);

    repeat (RandomCycles)
    begin
      for (int p = 0; p < NumPorts; p++)
      begin
        reqs[p]  = (takeBits(2) != 0);  // Mostly requesting.
        heads[p] = (takeBits(2) == 0);
      end
      drive(reqs, heads, int'(takeBits(3)));
    end
    repeat (3) drive(5'b00000, 5'b00000, 0);

    $display("Done: no errors");
    $finish;
  end

endmodule

/* outputArbiter.f */
common/routerPkg.sv
arbiter/grantFsm.sv
arbiter/holdTimers.sv
verilog/linkMux.sv
verilog/outputArbiter.sv
verif/tbOutputArbiter.sv

/* run.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tbOutputArbiter \
  -f outputArbiter.f \
  -o simOutputArbiter
if [ $? -ne 0 ]; then
  echo "Build failed."
  exit 1
fi

output="$(./obj_dir/simOutputArbiter 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status."
  exit 1
fi

if grep -q "^Done: no errors$" <<< "$output"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
